// ==== logic/turfio_cin_pkg.sv ====
package turfio_cin_pkg;

    // lane geometry
    localparam int NUM_LANES = 8;
    localparam int LANE_BITS = 3;

    // each lane delivers one nibble per clock
    localparam int NIBBLE_W = 4;
    localparam int WORD_W = 32;
    localparam int NIBBLES_PER_WORD = 8;

    // nibble phase counter inside a word
    localparam int PHASE_W = 3;

    // bit boundary offset, 32 positions
    localparam int SLIP_BITS = 5;

    // pattern sent by the far end while training
    localparam logic [WORD_W-1:0] TRAIN_WORD = 32'hA55A6996;

    // register address is {lane, register}
    localparam int ADDR_W = 7;
    localparam int REG_SEL_W = ADDR_W - LANE_BITS;

    // per-lane register map
    // ctrl bit 0 is lane reset, bit 1 is lock request
    localparam logic [REG_SEL_W-1:0] REG_CTRL = 4'd0;
    // status bit 0 is locked, bits 5:1 are the slip offset
    localparam logic [REG_SEL_W-1:0] REG_STATUS = 4'd1;
    // latched error count of the last full interval
    localparam logic [REG_SEL_W-1:0] REG_BITERR = 4'd2;
    // newest assembled word
    localparam logic [REG_SEL_W-1:0] REG_CAPTURE = 4'd3;
    // write only, any write slips one bit
    localparam logic [REG_SEL_W-1:0] REG_BITSLIP = 4'd4;
    // interval length in words, zero stops counting
    localparam logic [REG_SEL_W-1:0] REG_INTERVAL = 4'd5;

    // error count and interval width
    localparam int BITERR_W = 24;

endpackage

// ==== logic/cin_word_deser.sv ====
module cin_word_deser
    import turfio_cin_pkg::*;
(
    input  logic                 cin_clk_i,
    input  logic                 lane_rst_i,
    input  logic [NIBBLE_W-1:0]  nibble_i,
    input  logic                 slip_i,
    output logic [WORD_W-1:0]    word_o,
    output logic                 word_valid_o,
    output logic [SLIP_BITS-1:0] slip_offset_o
);

    // nibble from the last clock, low half of the history window
    logic [NIBBLE_W-1:0]        prev_nib;
    // two nibbles, earliest bit at bit 0
    logic [2*NIBBLE_W-1:0]      window;
    // nibble starting at the sub-nibble offset
    logic [NIBBLE_W-1:0]        aligned_nib;
    // first seven aligned nibbles of the word in flight
    logic [WORD_W-NIBBLE_W-1:0] acc;
    logic [PHASE_W-1:0]         phase;
    // slip waits here until the current word is finished
    logic                       slip_pend;
    // drop one nibble when the sub-nibble offset wraps
    logic                       skip;
    logic                       word_done;
    logic                       apply_slip;

    assign window = {nibble_i, prev_nib};
    assign aligned_nib = window[slip_offset_o[1:0] +: NIBBLE_W];
    assign word_done = (phase == PHASE_W'(NIBBLES_PER_WORD - 1));
    // boundary only moves between words so no word gets split
    assign apply_slip = slip_pend && word_done;

    // datapath
    always_ff @(posedge cin_clk_i) begin
        prev_nib <= nibble_i;
        if (!skip) begin
            // newest nibble enters at the top
            acc <= {aligned_nib, acc[WORD_W-NIBBLE_W-1:NIBBLE_W]};
        end
        if (word_done) begin
            word_o <= {aligned_nib, acc};
        end
    end

    // control
    always_ff @(posedge cin_clk_i) begin
        if (lane_rst_i) begin
            phase <= '0;
            slip_offset_o <= '0;
            slip_pend <= 1'b0;
            skip <= 1'b0;
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= word_done;
            // phase wraps by itself after the eighth nibble
            if (skip) begin
                skip <= 1'b0;
            end else begin
                phase <= phase + PHASE_W'(1);
            end
            if (slip_i) begin
                slip_pend <= 1'b1;
            end else if (apply_slip) begin
                slip_pend <= 1'b0;
            end
            if (apply_slip) begin
                slip_offset_o <= slip_offset_o + SLIP_BITS'(1);
                // 3 -> 0 means the boundary crossed into the next nibble
                if (slip_offset_o[1:0] == 2'b11) begin
                    skip <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/cin_lane_align.sv ====
module cin_lane_align
    import turfio_cin_pkg::*;
(
    input  logic              cin_clk_i,
    input  logic              lane_rst_i,
    input  logic              lock_req_i,
    input  logic [WORD_W-1:0] word_i,
    input  logic              word_valid_i,
    output logic              slip_o,
    output logic              locked_o,
    output logic              out_valid_o
);

    typedef enum logic [1:0] {
        ST_HUNT,
        ST_SKIP,
        ST_LOCKED
    } align_state_t;

    align_state_t state;
    logic         train_match;

    assign train_match = (word_i == TRAIN_WORD);

    always_ff @(posedge cin_clk_i) begin
        // dropping the request is treated like a lane reset here
        if (lane_rst_i || !lock_req_i) begin
            state <= ST_HUNT;
            slip_o <= 1'b0;
        end else begin
            slip_o <= 1'b0;
            case (state)
                ST_HUNT: begin
                    if (word_valid_i) begin
                        if (train_match) begin
                            state <= ST_LOCKED;
                        end else begin
                            // one bit later, and let the old-boundary word pass
                            slip_o <= 1'b1;
                            state <= ST_SKIP;
                        end
                    end
                end
                ST_SKIP: begin
                    // this word still sits on the old boundary
                    if (word_valid_i) begin
                        state <= ST_HUNT;
                    end
                end
                ST_LOCKED: begin
                    state <= ST_LOCKED;
                end
                default: begin
                    state <= ST_HUNT;
                end
            endcase
        end
    end

    assign locked_o = (state == ST_LOCKED);
    // no back-pressure, every locked word goes straight out
    assign out_valid_o = locked_o && word_valid_i;

    a_lock_needs_req: assert property (@(posedge cin_clk_i) disable iff (lane_rst_i)
        !lock_req_i |=> !locked_o);

endmodule

// ==== logic/biterr_interval_counter.sv ====
module biterr_interval_counter
    import turfio_cin_pkg::*;
(
    input  logic                cin_clk_i,
    input  logic                lane_rst_i,
    input  logic [BITERR_W-1:0] interval_i,
    input  logic                word_valid_i,
    input  logic                word_err_i,
    output logic [BITERR_W-1:0] count_o
);

    // words seen in this interval
    logic [BITERR_W-1:0] word_cnt;
    logic [BITERR_W-1:0] err_acc;
    // last interval value, a change restarts the count
    logic [BITERR_W-1:0] interval_q;
    logic [BITERR_W-1:0] err_inc;
    logic                last_word;

    assign err_inc = BITERR_W'(word_err_i);
    // >= so a shorter interval written mid-run still closes
    assign last_word = word_valid_i && (word_cnt >= interval_i - BITERR_W'(1));

    always_ff @(posedge cin_clk_i) begin
        if (lane_rst_i) begin
            word_cnt <= '0;
            err_acc <= '0;
            interval_q <= '0;
            count_o <= '0;
        end else begin
            interval_q <= interval_i;
            if (interval_i == '0 || interval_i != interval_q) begin
                // idle or restarting, count_o keeps the last result
                word_cnt <= '0;
                err_acc <= '0;
            end else if (last_word) begin
                // final word of the interval is included
                count_o <= err_acc + err_inc;
                word_cnt <= '0;
                err_acc <= '0;
            end else if (word_valid_i) begin
                word_cnt <= word_cnt + BITERR_W'(1);
                err_acc <= err_acc + err_inc;
            end
        end
    end

endmodule

// ==== logic/cin_lane.sv ====
module cin_lane
    import turfio_cin_pkg::*;
(
    input  logic                 cin_clk_i,
    input  logic                 rst,
    input  logic [NIBBLE_W-1:0]  nibble_i,
    input  logic                 we_i,
    input  logic [REG_SEL_W-1:0] reg_i,
    input  logic [WORD_W-1:0]    wdata_i,
    output logic [WORD_W-1:0]    rdata_o,
    output logic [WORD_W-1:0]    word_o,
    output logic                 word_valid_o
);

    // bit 0 lane reset, bit 1 lock request
    logic [1:0]           ctrl_q;
    logic [BITERR_W-1:0]  interval_q;
    logic [WORD_W-1:0]    capture_q;
    logic                 lane_rst;
    logic                 manual_slip;
    logic                 align_slip;
    logic                 slip;
    logic                 deser_valid;
    logic [SLIP_BITS-1:0] slip_offset;
    logic                 locked;
    logic                 word_err;
    logic [BITERR_W-1:0]  biterr_count;

    assign lane_rst = rst || ctrl_q[0];
    // write strobe on the bitslip register is the slip itself
    assign manual_slip = we_i && (reg_i == REG_BITSLIP);
    assign slip = manual_slip || align_slip;
    assign word_err = (word_o != TRAIN_WORD);

    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            ctrl_q <= '0;
            interval_q <= '0;
            capture_q <= '0;
        end else begin
            if (we_i && reg_i == REG_CTRL) begin
                ctrl_q <= wdata_i[1:0];
            end
            if (we_i && reg_i == REG_INTERVAL) begin
                interval_q <= wdata_i[BITERR_W-1:0];
            end
            // capture follows every word, locked or not
            if (deser_valid) begin
                capture_q <= word_o;
            end
        end
    end

    // readback for the selected register
    always_comb begin
        case (reg_i)
            REG_CTRL:     rdata_o = WORD_W'(ctrl_q);
            REG_STATUS:   rdata_o = WORD_W'({slip_offset, locked});
            REG_BITERR:   rdata_o = WORD_W'(biterr_count);
            REG_CAPTURE:  rdata_o = capture_q;
            REG_INTERVAL: rdata_o = WORD_W'(interval_q);
            default:      rdata_o = '0;
        endcase
    end

    cin_word_deser u_deser (
        .cin_clk_i     (cin_clk_i),
        .lane_rst_i    (lane_rst),
        .nibble_i      (nibble_i),
        .slip_i        (slip),
        .word_o        (word_o),
        .word_valid_o  (deser_valid),
        .slip_offset_o (slip_offset)
    );

    cin_lane_align u_align (
        .cin_clk_i    (cin_clk_i),
        .lane_rst_i   (lane_rst),
        .lock_req_i   (ctrl_q[1]),
        .word_i       (word_o),
        .word_valid_i (deser_valid),
        .slip_o       (align_slip),
        .locked_o     (locked),
        .out_valid_o  (word_valid_o)
    );

    // only locked words count
    biterr_interval_counter u_biterr (
        .cin_clk_i    (cin_clk_i),
        .lane_rst_i   (lane_rst),
        .interval_i   (interval_q),
        .word_valid_i (word_valid_o),
        .word_err_i   (word_err),
        .count_o      (biterr_count)
    );

endmodule

// ==== logic/cin_reg_access.sv ====
module cin_reg_access
    import turfio_cin_pkg::*;
(
    input  logic                           cin_clk_i,
    input  logic                           rst,
    input  logic                           req_valid_i,
    output logic                           req_ready_o,
    input  logic                           req_we_i,
    input  logic [ADDR_W-1:0]              req_addr_i,
    input  logic [WORD_W-1:0]              req_wdata_i,
    output logic                           resp_valid_o,
    input  logic                           resp_ready_i,
    output logic [WORD_W-1:0]              resp_rdata_o,
    output logic [WORD_W-1:0]              lane_wdata_o,
    output logic [NUM_LANES-1:0]           lane_we_o,
    output logic [NUM_LANES*REG_SEL_W-1:0] lane_reg_o,
    input  logic [NUM_LANES*WORD_W-1:0]    lane_rdata_i
);

    logic                 accept;
    logic [LANE_BITS-1:0] lane_sel;
    logic [REG_SEL_W-1:0] reg_sel;
    logic [WORD_W-1:0]    sel_rdata;

    // upper bits pick the lane, lower bits the register
    assign lane_sel = req_addr_i[ADDR_W-1 -: LANE_BITS];
    assign reg_sel = req_addr_i[REG_SEL_W-1:0];

    // one request in flight at a time
    assign req_ready_o = !resp_valid_o;
    assign accept = req_valid_i && req_ready_o;

    assign lane_wdata_o = req_wdata_i;
    assign sel_rdata = lane_rdata_i[lane_sel*WORD_W +: WORD_W];

    // every lane sees the register number, only one gets the strobe
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_we_o[i] = accept && req_we_i && (lane_sel == LANE_BITS'(i));
            lane_reg_o[i*REG_SEL_W +: REG_SEL_W] = reg_sel;
        end
    end

    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            resp_valid_o <= 1'b0;
        end else if (accept) begin
            resp_valid_o <= 1'b1;
        end else if (resp_ready_i) begin
            resp_valid_o <= 1'b0;
        end
    end

    // readback sampled on the accepting edge
    always_ff @(posedge cin_clk_i) begin
        if (accept) begin
            // writes answer with zero
            resp_rdata_o <= req_we_i ? '0 : sel_rdata;
        end
    end

    // held response must not change under the consumer
    a_resp_stable: assert property (@(posedge cin_clk_i) disable iff (rst)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_rdata_o));

    // each acceptance opens a response that blocks the next request
    a_single_outstanding: assert property (@(posedge cin_clk_i) disable iff (rst)
        accept |=> resp_valid_o && !accept);

endmodule

// ==== logic/turfio_cin_if.sv ====
module turfio_cin_if
    import turfio_cin_pkg::*;
(
    input  logic                          cin_clk_i,
    input  logic                          rst,
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    input  logic                          req_we_i,
    input  logic [ADDR_W-1:0]             req_addr_i,
    input  logic [WORD_W-1:0]             req_wdata_i,
    output logic                          resp_valid_o,
    input  logic                          resp_ready_i,
    output logic [WORD_W-1:0]             resp_rdata_o,
    input  logic [NUM_LANES*NIBBLE_W-1:0] cin_data_i,
    output logic [NUM_LANES*WORD_W-1:0]   cin_word_o,
    output logic [NUM_LANES-1:0]          cin_valid_o
);

    // shared register bus toward the lanes
    logic [WORD_W-1:0]              lane_wdata;
    logic [NUM_LANES-1:0]           lane_we;
    logic [NUM_LANES*REG_SEL_W-1:0] lane_reg;
    logic [NUM_LANES*WORD_W-1:0]    lane_rdata;

    cin_reg_access u_reg_access (
        .cin_clk_i    (cin_clk_i),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_we_i     (req_we_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_rdata_o (resp_rdata_o),
        .lane_wdata_o (lane_wdata),
        .lane_we_o    (lane_we),
        .lane_reg_o   (lane_reg),
        .lane_rdata_i (lane_rdata)
    );

    // lane 0 sits in the lowest slice of every packed bus
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        cin_lane u_lane (
            .cin_clk_i    (cin_clk_i),
            .rst          (rst),
            .nibble_i     (cin_data_i[i*NIBBLE_W +: NIBBLE_W]),
            .we_i         (lane_we[i]),
            .reg_i        (lane_reg[i*REG_SEL_W +: REG_SEL_W]),
            .wdata_i      (lane_wdata),
            .rdata_o      (lane_rdata[i*WORD_W +: WORD_W]),
            .word_o       (cin_word_o[i*WORD_W +: WORD_W]),
            .word_valid_o (cin_valid_o[i])
        );
    end

endmodule

// ==== tests/cin_lane_model.svh ====
`ifndef CIN_LANE_MODEL_SVH
`define CIN_LANE_MODEL_SVH

// word a lane's stream carries at word index widx
function automatic logic [WORD_W-1:0] stream_word(input int lane, input int widx);
    int rel;
    rel = widx - sched_start[lane];
    if (sched_len[lane] > 0 && rel >= 0) begin
        if (sched_repeat[lane]) begin
            return sched_data[lane][rel % sched_len[lane]];
        end else if (rel < sched_len[lane]) begin
            return sched_data[lane][rel];
        end
    end
    return base_word[lane];
endfunction

// serializer, nibble bit 0 is the earliest bit on the wire
function automatic logic [NIBBLE_W-1:0] stream_nibble(input int lane, input int c);
    logic [NIBBLE_W-1:0] nib;
    logic [WORD_W-1:0]   w;
    int                  m;
    for (int j = 0; j < NIBBLE_W; j++) begin
        m = NIBBLE_W * c + j + phase[lane];
        w = stream_word(lane, m / WORD_W);
        nib[j] = w[m % WORD_W];
    end
    return nib;
endfunction

// index of the stream word now on the wire
function automatic int stream_widx(input int lane);
    return (NIBBLE_W * cyc + phase[lane]) / WORD_W;
endfunction

// word boundary at offset 0 starts one nibble before reset release
function automatic int base_boundary();
    return (NIBBLE_W * (RST_CYCLES - 1)) % WORD_W;
endfunction

// offset at which the training word lines up
function automatic int expected_offset(input int lane);
    return (2 * WORD_W - base_boundary() - phase[lane]) % WORD_W;
endfunction

// word read from a repeated word k, starting shift bits into it
function automatic logic [WORD_W-1:0] boundary_word(input logic [WORD_W-1:0] k,
                                                    input int shift);
    logic [WORD_W-1:0] w;
    for (int i = 0; i < WORD_W; i++) begin
        w[i] = k[(i + shift) % WORD_W];
    end
    return w;
endfunction

function automatic logic [ADDR_W-1:0] lane_addr(input int lane, input logic [REG_SEL_W-1:0] r);
    return {LANE_BITS'(lane), r};
endfunction

// drive one request, the response is due one cycle after acceptance
task automatic issue_req(input logic we, input logic [ADDR_W-1:0] addr,
                         input logic [WORD_W-1:0] wdata);
    int waited;
    waited = 0;
    @(negedge cin_clk_i);
    req_valid_i = 1'b1;
    req_we_i = we;
    req_addr_i = addr;
    req_wdata_i = wdata;
    while (!req_ready_o && waited < 16) begin
        @(negedge cin_clk_i);
        waited++;
    end
    assert (req_ready_o) else begin
        $display("request to address %h was never accepted", addr);
        errors++;
    end
    @(posedge cin_clk_i);
    @(negedge cin_clk_i);
    req_valid_i = 1'b0;
    req_we_i = 1'b0;
    assert (resp_valid_o) else begin
        $display("no response one cycle after the request to address %h", addr);
        errors++;
    end
endtask

task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] wdata);
    issue_req(1'b1, addr, wdata);
    // a write answers with zero data
    check_value("write response data", '0, resp_rdata_o);
endtask

task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] data);
    issue_req(1'b0, addr, '0);
    data = resp_rdata_o;
endtask

// read with the response held off for hold cycles
task automatic reg_read_held(input logic [ADDR_W-1:0] addr, input int hold,
                             output logic [WORD_W-1:0] data);
    @(negedge cin_clk_i);
    resp_ready_i = 1'b0;
    issue_req(1'b0, addr, '0);
    data = resp_rdata_o;
    // a second read of a neighbour register waits behind the held response
    req_valid_i = 1'b1;
    req_addr_i = addr ^ ADDR_W'(1);
    for (int i = 0; i < hold; i++) begin
        @(negedge cin_clk_i);
        check_value("held resp_valid", 32'd1, WORD_W'(resp_valid_o));
        check_value("held req_ready", 32'd0, WORD_W'(req_ready_o));
        check_value("held resp_rdata", data, resp_rdata_o);
    end
    req_valid_i = 1'b0;
    resp_ready_i = 1'b1;
    @(negedge cin_clk_i);
    check_value("req_ready after take", 32'd1, WORD_W'(req_ready_o));
endtask

`endif

// ==== tests/turfio_cin_tb.sv ====
module turfio_cin_tb
    import turfio_cin_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES = 16;
    localparam int N_ENTRIES = 20;
    // worst entry is a lock hunt of 64 words plus register traffic
    localparam int ENTRY_CYCLES = 1000;
    localparam int LOCK_CYCLES = 64 * NIBBLES_PER_WORD + 64;
    localparam int RX_DEPTH = 256;

    typedef enum int {T_RESET, T_LOCK, T_DELIVER, T_BITERR, T_SLIP, T_HOLD} test_kind_t;

    logic                          cin_clk_i = 1'b0;
    logic                          rst = 1'b1;
    logic                          req_valid_i;
    logic                          req_ready_o;
    logic                          req_we_i;
    logic [ADDR_W-1:0]             req_addr_i;
    logic [WORD_W-1:0]             req_wdata_i;
    logic                          resp_valid_o;
    logic                          resp_ready_i;
    logic [WORD_W-1:0]             resp_rdata_o;
    logic [NUM_LANES*NIBBLE_W-1:0] cin_data_i = '0;
    logic [NUM_LANES*WORD_W-1:0]   cin_word_o;
    logic [NUM_LANES-1:0]          cin_valid_o;

    // stream model state per lane
    int                cyc = 0;
    int                phase [NUM_LANES];
    logic [WORD_W-1:0] base_word [NUM_LANES];
    logic [WORD_W-1:0] sched_data [NUM_LANES][16];
    int                sched_start [NUM_LANES];
    int                sched_len [NUM_LANES];
    bit                sched_repeat [NUM_LANES];
    // non-training words seen on cin_word_o
    logic [WORD_W-1:0] rx_data [NUM_LANES][RX_DEPTH];
    int                rx_cnt [NUM_LANES];
    int                pulse_cnt = 0;

    string             t_name [N_ENTRIES];
    int                t_lane [N_ENTRIES];
    test_kind_t        t_kind [N_ENTRIES];
    logic [REG_SEL_W-1:0] t_reg [N_ENTRIES];
    logic [WORD_W-1:0] t_value [N_ENTRIES];
    int                n_entries = 0;
    int                checks = 0;
    int                errors = 0;

    task automatic check_value(input string name, input logic [WORD_W-1:0] exp,
                               input logic [WORD_W-1:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

`include "cin_lane_model.svh"

    turfio_cin_if turfio_cin_if_inst (.*);

    always #4 cin_clk_i = ~cin_clk_i;

    // serializer, one nibble per lane per clock
    always @(negedge cin_clk_i) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            cin_data_i[l*NIBBLE_W +: NIBBLE_W] = stream_nibble(l, cyc);
        end
        if (cyc == RST_CYCLES) begin
            rst = 1'b0;
        end
        cyc++;
    end

    // word output monitor
    always @(negedge cin_clk_i) begin : rx_monitor
        logic [WORD_W-1:0] w;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (cin_valid_o[l]) begin
                pulse_cnt++;
                w = cin_word_o[l*WORD_W +: WORD_W];
                if (w != TRAIN_WORD && rx_cnt[l] < RX_DEPTH) begin
                    rx_data[l][rx_cnt[l]] = w;
                    rx_cnt[l]++;
                end
            end
        end
    end

    task automatic add_entry(input string name, input int lane, input test_kind_t kind,
                             input logic [REG_SEL_W-1:0] r, input logic [WORD_W-1:0] value);
        t_name[n_entries] = name;
        t_lane[n_entries] = lane;
        t_kind[n_entries] = kind;
        t_reg[n_entries] = r;
        t_value[n_entries] = value;
        n_entries++;
    endtask

    task automatic run_entry(input int e);
        logic [WORD_W-1:0] rd;
        logic [WORD_W-1:0] stat;
        int                l;
        int                start;
        int                mark;
        int                k;
        int                off0;
        l = t_lane[e];
        case (t_kind[e])
            T_RESET: begin
                // capture follows raw words, so it is left out here
                reg_read(lane_addr(l, REG_CTRL), rd);
                check_value(t_name[e], t_value[e], rd);
                reg_read(lane_addr(l, REG_STATUS), rd);
                check_value(t_name[e], t_value[e], rd);
                reg_read(lane_addr(l, REG_BITERR), rd);
                check_value(t_name[e], t_value[e], rd);
                reg_read(lane_addr(l, REG_INTERVAL), rd);
                check_value(t_name[e], t_value[e], rd);
                reg_read(lane_addr(l, 4'd7), rd);
                check_value(t_name[e], t_value[e], rd);
                check_value({t_name[e], " pulses"}, '0, WORD_W'(pulse_cnt));
            end
            T_LOCK: begin
                reg_write(lane_addr(l, REG_CTRL), 32'd2);
                start = cyc;
                stat = '0;
                while (!stat[0] && cyc - start < LOCK_CYCLES) begin
                    reg_read(lane_addr(l, REG_STATUS), stat);
                end
                check_value({t_name[e], " status"},
                            WORD_W'({SLIP_BITS'(expected_offset(l)), 1'b1}), stat);
                reg_read(lane_addr(l, t_reg[e]), rd);
                check_value(t_name[e], t_value[e], rd);
            end
            T_DELIVER: begin
                k = int'(t_value[e]);
                for (int i = 0; i < k; i++) begin
                    sched_data[l][i] = $urandom() | 32'h1;
                    if (sched_data[l][i] == TRAIN_WORD) begin
                        sched_data[l][i] = ~TRAIN_WORD;
                    end
                end
                mark = rx_cnt[l];
                sched_repeat[l] = 1'b0;
                sched_start[l] = stream_widx(l) + 3;
                sched_len[l] = k;
                while (stream_widx(l) < sched_start[l] + k + 3) begin
                    @(negedge cin_clk_i);
                end
                check_value({t_name[e], " count"}, t_value[e], WORD_W'(rx_cnt[l] - mark));
                for (int i = 0; i < k && mark + i < rx_cnt[l]; i++) begin
                    check_value(t_name[e], sched_data[l][i], rx_data[l][mark + i]);
                end
                sched_len[l] = 0;
            end
            T_BITERR: begin
                k = int'(t_value[e]);
                reg_write(lane_addr(l, REG_INTERVAL), 32'd16);
                // periodic pattern so every 16-word interval holds k errors
                for (int p = 0; p < 16; p++) begin
                    sched_data[l][p] = (p < k) ? (TRAIN_WORD ^ (32'h1 << p)) : TRAIN_WORD;
                end
                sched_repeat[l] = 1'b1;
                sched_start[l] = stream_widx(l) + 3;
                sched_len[l] = 16;
                while (stream_widx(l) < sched_start[l] + 3 * 16 + 2) begin
                    @(negedge cin_clk_i);
                end
                reg_read(lane_addr(l, t_reg[e]), rd);
                check_value(t_name[e], t_value[e], rd);
            end
            T_SLIP: begin
                reg_write(lane_addr(l, REG_CTRL), 32'd0);
                base_word[l] = t_value[e];
                // let two whole words of the new stream go by
                repeat (3 * NIBBLES_PER_WORD) @(negedge cin_clk_i);
                // lane keeps the offset it locked at
                off0 = expected_offset(l);
                reg_read(lane_addr(l, REG_STATUS), stat);
                check_value({t_name[e], " unlocked"}, WORD_W'({SLIP_BITS'(off0), 1'b0}), stat);
                reg_write(lane_addr(l, REG_BITSLIP), 32'd1);
                start = cyc;
                while (stat[SLIP_BITS:1] != SLIP_BITS'(off0 + 1) && cyc - start < 64) begin
                    reg_read(lane_addr(l, REG_STATUS), stat);
                end
                check_value({t_name[e], " offset"}, WORD_W'(SLIP_BITS'(off0 + 1)),
                            WORD_W'(stat[SLIP_BITS:1]));
                // next word is at most 9 cycles out, capture one cycle later
                repeat (20) @(negedge cin_clk_i);
                reg_read(lane_addr(l, t_reg[e]), rd);
                check_value(t_name[e],
                            boundary_word(t_value[e], base_boundary() + off0 + 1 + phase[l]),
                            rd);
            end
            T_HOLD: begin
                reg_read_held(lane_addr(l, t_reg[e]), int'($urandom_range(10, 3)), rd);
                check_value(t_name[e], t_value[e], rd);
            end
            default: begin
                $display("unknown test kind in entry %0d", e);
                errors++;
            end
        endcase
    endtask

    initial begin
        void'($urandom(69));
        req_valid_i = 1'b0;
        req_we_i = 1'b0;
        req_addr_i = '0;
        req_wdata_i = '0;
        resp_ready_i = 1'b1;
        for (int l = 0; l < NUM_LANES; l++) begin
            phase[l] = int'($urandom_range(WORD_W - 1, 0));
            base_word[l] = TRAIN_WORD;
            sched_start[l] = 0;
            sched_len[l] = 0;
            sched_repeat[l] = 1'b0;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            add_entry($sformatf("reset_lane%0d", l), l, T_RESET, REG_CTRL, '0);
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            add_entry($sformatf("lock_lane%0d", l), l, T_LOCK, REG_CAPTURE, TRAIN_WORD);
        end
        add_entry("deliver_lane1", 1, T_DELIVER, REG_CAPTURE, 32'd6);
        add_entry("biterr_lane2", 2, T_BITERR, REG_BITERR, 32'd5);
        add_entry("bitslip_lane7", 7, T_SLIP, REG_CAPTURE, 32'h3C96_0FE1);
        add_entry("hold_lane2", 2, T_HOLD, REG_INTERVAL, 32'd16);
        wait (rst == 1'b0);
        repeat (2) @(negedge cin_clk_i);
        for (int e = 0; e < n_entries; e++) begin
            run_entry(e);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        #((N_ENTRIES * ENTRY_CYCLES + 4 * RST_CYCLES) * 8);
        $display("watchdog expired before the test table finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== turfio_cin_if.f ====
+incdir+tests
logic/turfio_cin_pkg.sv
logic/cin_word_deser.sv
logic/cin_lane_align.sv
logic/biterr_interval_counter.sv
logic/cin_lane.sv
logic/cin_reg_access.sv
logic/turfio_cin_if.sv
tests/turfio_cin_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the turfio_cin testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f turfio_cin_if.f \
    --top-module turfio_cin_tb \
    -o turfio_cin_tb

./obj_dir/turfio_cin_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
